// ==== hw/pdh_defines.svh ====
`ifndef PDH_DEFINES_SVH
`define PDH_DEFINES_SVH

// Bus and word widths
`define PDH_ADC_WIDTH     14
`define PDH_DAC_WIDTH     14
`define PDH_GPIO_WIDTH    32
`define PDH_SAMPLE_WIDTH  16

// Command word layout
`define PDH_STROBE_BIT    30
`define PDH_CMD_MSB       29
`define PDH_CMD_LSB       26
`define PDH_DATA_MSB      25

// Signal path constants
`define PDH_ADC_OFFSET    8192
`define PDH_DAC_MIDSCALE  14'h2000
`define PDH_UNITY_COEFF   16'h7FFF
`define PDH_ROT_SHIFT     15

`endif

// ==== hw/pdh_pkg.sv ====
`default_nettype none

`include "pdh_defines.svh"

package pdh_pkg;

    // Host command codes
    typedef enum logic [`PDH_CMD_MSB-`PDH_CMD_LSB:0] {
        CMD_IDLE              = 4'd0,
        CMD_SET_LED           = 4'd1,
        CMD_SET_DAC           = 4'd2,
        CMD_GET_ADC           = 4'd3,
        CMD_CHECK_SIGNED      = 4'd4,
        CMD_SET_ROT_COEFFS    = 4'd5,
        CMD_COMMIT_ROT_COEFFS = 4'd6
    } cmd_t;

    typedef logic [`PDH_GPIO_WIDTH-1:0] gpio_word_t;

    typedef logic [`PDH_ADC_WIDTH-1:0] adc_word_t;

    // Also used for the rotation coefficients
    typedef logic signed [`PDH_SAMPLE_WIDTH-1:0] sample_t;

    typedef logic [`PDH_DAC_WIDTH-1:0] dac_code_t;

    typedef logic [7:0] led_t;

    typedef logic dac_ch_t;  // 0 selects channel 1

endpackage

`default_nettype wire

// ==== hw/pdh_cmd_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pdh_defines.svh"

module pdh_cmd_capture
    import pdh_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_i,
    input  gpio_word_t             axi_from_ps_i,
    output cmd_t                   cmd_o,
    output logic [`PDH_DATA_MSB:0] data_o
);

    logic [1:0] strobe_sync_r;   // Two-flop synchroniser
    logic       strobe_prev_r;
    logic       strobe_rise_r;
    gpio_word_t word_r;

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            strobe_sync_r <= 2'b00;
            strobe_prev_r <= 1'b0;
            strobe_rise_r <= 1'b0;
            word_r        <= '0;
        end else begin
            strobe_sync_r <= {strobe_sync_r[0], axi_from_ps_i[`PDH_STROBE_BIT]};
            strobe_prev_r <= strobe_sync_r[1];
            strobe_rise_r <= strobe_sync_r[1] & ~strobe_prev_r;
            if (strobe_rise_r) begin
                word_r <= axi_from_ps_i;  // Host holds the word stable around the strobe
            end
        end
    end

    // Undefined codes pass through, the decoder ignores them
    assign cmd_o  = cmd_t'(word_r[`PDH_CMD_MSB:`PDH_CMD_LSB]);
    assign data_o = word_r[`PDH_DATA_MSB:0];

endmodule

`default_nettype wire

// ==== hw/pdh_ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pdh_defines.svh"

module pdh_ctrl_regs
    import pdh_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_i,
    input  cmd_t                   cmd_i,
    input  logic [`PDH_DATA_MSB:0] data_i,
    input  adc_word_t              adc_a_raw_i,
    input  adc_word_t              adc_b_raw_i,
    input  sample_t                a_i,
    input  sample_t                b_i,
    input  sample_t                i_i,
    input  sample_t                q_i,
    input  dac_code_t              dac1_i,
    input  dac_code_t              dac2_i,
    output led_t                   led_o,
    output sample_t                rot_cos_o,
    output sample_t                rot_sin_o,
    output logic                   dac_we_o,
    output dac_ch_t                dac_ch_o,
    output dac_code_t              dac_val_o,
    output gpio_word_t             axi_to_ps_o
);

    led_t       led_r, led_next;
    sample_t    cos_r, cos_next;          // Staged pair
    sample_t    sin_r, sin_next;
    sample_t    rot_cos_r, rot_cos_next;  // Committed pair
    sample_t    rot_sin_r, rot_sin_next;
    gpio_word_t rb_r, rb_next;
    sample_t    check_val;

    ////////////////////////////////////////////////////////////////////////////
    // CHECK_SIGNED value select

    always_comb begin
        case (data_i[4:0])
            5'd0:    check_val = a_i;
            5'd1:    check_val = b_i;
            5'd2:    check_val = cos_r;
            5'd3:    check_val = sin_r;
            5'd4:    check_val = rot_cos_r;
            5'd5:    check_val = rot_sin_r;
            5'd6:    check_val = i_i;
            5'd7:    check_val = q_i;
            default: check_val = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Command decode

    always_comb begin
        led_next     = led_r;
        cos_next     = cos_r;
        sin_next     = sin_r;
        rot_cos_next = rot_cos_r;
        rot_sin_next = rot_sin_r;
        rb_next      = '0;  // IDLE and unknown codes
        case (cmd_i)
            CMD_SET_LED: begin
                led_next = data_i[7:0];
                rb_next  = {CMD_SET_LED, 20'd0, led_next};
            end
            CMD_SET_DAC: begin
                rb_next = {CMD_SET_DAC, dac1_i, dac2_i};
            end
            CMD_GET_ADC: begin
                rb_next = {CMD_GET_ADC, adc_b_raw_i, adc_a_raw_i};
            end
            CMD_CHECK_SIGNED: begin
                rb_next = {CMD_CHECK_SIGNED, 7'd0, data_i[4:0], check_val};
            end
            CMD_SET_ROT_COEFFS: begin
                if (data_i[16]) begin
                    sin_next = data_i[15:0];
                end else begin
                    cos_next = data_i[15:0];
                end
                rb_next = {CMD_SET_ROT_COEFFS, sin_next[15:2], cos_next[15:2]};
            end
            CMD_COMMIT_ROT_COEFFS: begin
                rot_cos_next = cos_r;
                rot_sin_next = sin_r;
                rb_next      = {CMD_COMMIT_ROT_COEFFS, q_i[15:2], i_i[15:2]};
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            led_r     <= '0;
            cos_r     <= `PDH_UNITY_COEFF;
            sin_r     <= '0;
            rot_cos_r <= `PDH_UNITY_COEFF;
            rot_sin_r <= '0;
            rb_r      <= '0;
        end else begin
            led_r     <= led_next;
            cos_r     <= cos_next;
            sin_r     <= sin_next;
            rot_cos_r <= rot_cos_next;
            rot_sin_r <= rot_sin_next;
            rb_r      <= rb_next;
        end
    end

    // Write request stays up as long as SET_DAC is latched
    assign dac_we_o  = (cmd_i == CMD_SET_DAC);
    assign dac_ch_o  = data_i[14];
    assign dac_val_o = data_i[13:0];

    assign led_o       = led_r;
    assign rot_cos_o   = rot_cos_r;
    assign rot_sin_o   = rot_sin_r;
    assign axi_to_ps_o = rb_r;

endmodule

`default_nettype wire

// ==== hw/pdh_adc_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pdh_defines.svh"

module pdh_adc_frontend
    import pdh_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  adc_word_t adc_dat_a_i,
    input  adc_word_t adc_dat_b_i,
    output sample_t   a_o,
    output sample_t   b_o
);

    // Mid-scale minus raw code, inverts the front-end polarity
    function automatic sample_t remove_offset(input adc_word_t raw);
        sample_t wide;
        wide = sample_t'({{(`PDH_SAMPLE_WIDTH-`PDH_ADC_WIDTH){1'b0}}, raw});
        return sample_t'(`PDH_ADC_OFFSET) - wide;
    endfunction

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            a_o <= '0;
            b_o <= '0;
        end else begin
            a_o <= remove_offset(adc_dat_a_i);
            b_o <= remove_offset(adc_dat_b_i);
        end
    end

endmodule

`default_nettype wire

// ==== hw/pdh_iq_rotator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pdh_defines.svh"

module pdh_iq_rotator
    import pdh_pkg::*;
(
    input  logic    clk,
    input  logic    rst_i,
    input  sample_t a_i,
    input  sample_t b_i,
    input  sample_t cos_i,
    input  sample_t sin_i,
    output sample_t i_o,
    output sample_t q_o
);

    logic signed [2*`PDH_SAMPLE_WIDTH-1:0] i_full;
    logic signed [2*`PDH_SAMPLE_WIDTH-1:0] q_full;

    always_comb begin
        i_full = cos_i * a_i - sin_i * b_i;
        q_full = sin_i * a_i + cos_i * b_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Q1.15 coefficients, drop the fraction and keep the low word

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            i_o <= '0;
            q_o <= '0;
        end else begin
            i_o <= sample_t'(i_full >>> `PDH_ROT_SHIFT);
            q_o <= sample_t'(q_full >>> `PDH_ROT_SHIFT);
        end
    end

endmodule

`default_nettype wire

// ==== hw/pdh_dac_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pdh_defines.svh"

module pdh_dac_mux
    import pdh_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      dac_we_i,
    input  dac_ch_t   dac_ch_i,
    input  dac_code_t dac_val_i,
    output dac_code_t dac1_o,
    output dac_code_t dac2_o,
    output dac_code_t dac_dat_o,
    output logic      dac_sel_o,
    output logic      dac_rst_o
);

    dac_code_t dac1_r;
    dac_code_t dac2_r;
    logic      sel_r;
    logic      dac_rst_r;

    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            dac1_r <= `PDH_DAC_MIDSCALE;
            dac2_r <= `PDH_DAC_MIDSCALE;
            sel_r  <= 1'b0;
        end else begin
            sel_r <= ~sel_r;  // Interleave the two channels
            if (dac_we_i) begin
                if (dac_ch_i) begin
                    dac2_r <= dac_val_i;
                end else begin
                    dac1_r <= dac_val_i;
                end
            end
        end
    end

    // Held for one clock past reset release
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            dac_rst_r <= 1'b1;
        end else begin
            dac_rst_r <= 1'b0;
        end
    end

    assign dac_dat_o = sel_r ? dac2_r : dac1_r;
    assign dac_sel_o = sel_r;
    assign dac_rst_o = dac_rst_r;
    assign dac1_o    = dac1_r;
    assign dac2_o    = dac2_r;

endmodule

`default_nettype wire

// ==== hw/pdh_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pdh_defines.svh"

module pdh_core
    import pdh_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  adc_word_t  adc_dat_a_i,
    input  adc_word_t  adc_dat_b_i,
    input  gpio_word_t axi_from_ps_i,
    output gpio_word_t axi_to_ps_o,
    output led_t       led_o,
    output dac_code_t  dac_dat_o,
    output logic       dac_sel_o,
    output logic       dac_rst_o
);

    cmd_t                   cmd_w;
    logic [`PDH_DATA_MSB:0] data_w;
    sample_t                a_w, b_w;
    sample_t                i_w, q_w;
    sample_t                rot_cos_w, rot_sin_w;
    logic                   dac_we_w;
    dac_ch_t                dac_ch_w;
    dac_code_t              dac_val_w;
    dac_code_t              dac1_w, dac2_w;

    ////////////////////////////////////////////////////////////////////////////
    // Host command path

    pdh_cmd_capture i_cmd_capture (
        .clk           (clk),
        .rst_i         (rst_i),
        .axi_from_ps_i (axi_from_ps_i),
        .cmd_o         (cmd_w),
        .data_o        (data_w)
    );

    pdh_ctrl_regs i_ctrl_regs (
        .clk         (clk),
        .rst_i       (rst_i),
        .cmd_i       (cmd_w),
        .data_i      (data_w),
        .adc_a_raw_i (adc_dat_a_i),
        .adc_b_raw_i (adc_dat_b_i),
        .a_i         (a_w),
        .b_i         (b_w),
        .i_i         (i_w),
        .q_i         (q_w),
        .dac1_i      (dac1_w),
        .dac2_i      (dac2_w),
        .led_o       (led_o),
        .rot_cos_o   (rot_cos_w),
        .rot_sin_o   (rot_sin_w),
        .dac_we_o    (dac_we_w),
        .dac_ch_o    (dac_ch_w),
        .dac_val_o   (dac_val_w),
        .axi_to_ps_o (axi_to_ps_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Signal path

    pdh_adc_frontend i_adc_frontend (
        .clk         (clk),
        .rst_i       (rst_i),
        .adc_dat_a_i (adc_dat_a_i),
        .adc_dat_b_i (adc_dat_b_i),
        .a_o         (a_w),
        .b_o         (b_w)
    );

    pdh_iq_rotator i_iq_rotator (
        .clk   (clk),
        .rst_i (rst_i),
        .a_i   (a_w),
        .b_i   (b_w),
        .cos_i (rot_cos_w),
        .sin_i (rot_sin_w),
        .i_o   (i_w),
        .q_o   (q_w)
    );

    pdh_dac_mux i_dac_mux (
        .clk       (clk),
        .rst_i     (rst_i),
        .dac_we_i  (dac_we_w),
        .dac_ch_i  (dac_ch_w),
        .dac_val_i (dac_val_w),
        .dac1_o    (dac1_w),
        .dac2_o    (dac2_w),
        .dac_dat_o (dac_dat_o),
        .dac_sel_o (dac_sel_o),
        .dac_rst_o (dac_rst_o)
    );

endmodule

`default_nettype wire

// ==== tb/pdh_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pdh_defines.svh"

module pdh_core_tb
    import pdh_pkg::*;
();

    localparam int CLK_HALF    = 10;
    localparam int DRIVE_DELAY = 2;
    localparam int WAIT_LIMIT  = 50;

    typedef struct {
        string                  name;
        cmd_t                   cmd;
        logic [`PDH_DATA_MSB:0] data;
        adc_word_t              adc_a;
        adc_word_t              adc_b;
        gpio_word_t             expected;
    } row_t;

    logic       clk;
    logic       rst_i;
    adc_word_t  adc_dat_a;
    adc_word_t  adc_dat_b;
    gpio_word_t axi_from_ps;
    gpio_word_t axi_to_ps;
    led_t       led;
    dac_code_t  dac_dat;
    logic       dac_sel;
    logic       dac_rst;

    row_t      rows[$];
    int        value_errors = 0;
    int        timeouts     = 0;
    adc_word_t ra, rb, rc, rd;  // Random ADC words
    sample_t   stage_cos, stage_sin;
    sample_t   rot_i, rot_q;

    pdh_core i_dut (
        .clk           (clk),
        .rst_i         (rst_i),
        .adc_dat_a_i   (adc_dat_a),
        .adc_dat_b_i   (adc_dat_b),
        .axi_from_ps_i (axi_from_ps),
        .axi_to_ps_o   (axi_to_ps),
        .led_o         (led),
        .dac_dat_o     (dac_dat),
        .dac_sel_o     (dac_sel),
        .dac_rst_o     (dac_rst)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    function automatic sample_t expect_offset(input adc_word_t raw);
        int diff;
        diff = `PDH_ADC_OFFSET - int'(raw);
        return sample_t'(diff);
    endfunction

    function automatic sample_t expect_i(input sample_t c, input sample_t s,
                                         input sample_t a, input sample_t b);
        int acc;
        acc = int'(c) * int'(a) - int'(s) * int'(b);
        return sample_t'(acc >>> `PDH_ROT_SHIFT);
    endfunction

    function automatic sample_t expect_q(input sample_t c, input sample_t s,
                                         input sample_t a, input sample_t b);
        int acc;
        acc = int'(s) * int'(a) + int'(c) * int'(b);
        return sample_t'(acc >>> `PDH_ROT_SHIFT);
    endfunction

    function automatic gpio_word_t signed_word(input logic [4:0] sel, input sample_t val);
        return {CMD_CHECK_SIGNED, 7'd0, sel, val};
    endfunction

    function automatic gpio_word_t cmd_word(input logic strobe, input cmd_t cmd,
                                            input logic [`PDH_DATA_MSB:0] data);
        gpio_word_t w;
        w = '0;
        w[`PDH_STROBE_BIT]            = strobe;
        w[`PDH_CMD_MSB:`PDH_CMD_LSB] = cmd;
        w[`PDH_DATA_MSB:0]            = data;
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks

    task automatic check_word(input string name, input gpio_word_t exp, input gpio_word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_dac(input string name, input dac_code_t exp, input dac_code_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_led(input string name, input led_t exp, input led_t act);
        if (act !== exp) begin
            value_errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic add_row(input string name, input cmd_t cmd,
                           input logic [`PDH_DATA_MSB:0] data, input adc_word_t a,
                           input adc_word_t b, input gpio_word_t exp);
        row_t r;
        r.name     = name;
        r.cmd      = cmd;
        r.data     = data;
        r.adc_a    = a;
        r.adc_b    = b;
        r.expected = exp;
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r);
        int n;
        adc_dat_a   = r.adc_a;
        adc_dat_b   = r.adc_b;
        axi_from_ps = '0;  // Strobe low before the IDLE edge
        repeat (4) tick();
        axi_from_ps = cmd_word(1'b1, CMD_IDLE, '0);
        n = 0;
        tick();
        while (axi_to_ps !== '0 && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (axi_to_ps !== '0) begin
            timeouts++;
            $display("Readback did not clear after IDLE before step %s", r.name);
        end
        axi_from_ps = '0;
        repeat (4) tick();
        axi_from_ps = cmd_word(1'b1, r.cmd, r.data);
        n = 0;
        tick();
        while (axi_to_ps[31:28] !== r.cmd && n < WAIT_LIMIT) begin
            tick();
            n++;
        end
        if (axi_to_ps[31:28] !== r.cmd) begin
            timeouts++;
            $display("Command of step %s never showed up on the readback", r.name);
        end
        repeat (3) tick();  // Data path settles
        check_word(r.name, r.expected, axi_to_ps);
    endtask

    task automatic build_table();
        sample_t a0, b0, a1, b1;
        a0        = expect_offset(ra);
        b0        = expect_offset(rb);
        a1        = expect_offset(rc);
        b1        = expect_offset(rd);
        stage_cos = 16'h5A82;  // cos 45 deg
        stage_sin = 16'hA57E;  // -sin 45 deg
        rot_i     = expect_i(stage_cos, stage_sin, a1, b1);
        rot_q     = expect_q(stage_cos, stage_sin, a1, b1);

        add_row("reset_rot_cos", CMD_CHECK_SIGNED, 26'd4, ra, rb,
                signed_word(5'd4, `PDH_UNITY_COEFF));
        add_row("set_led", CMD_SET_LED, 26'h01234A5, ra, rb, {CMD_SET_LED, 20'd0, 8'hA5});
        add_row("set_dac_ch1", CMD_SET_DAC, 26'h0001234, ra, rb,
                {CMD_SET_DAC, 14'h1234, `PDH_DAC_MIDSCALE});
        add_row("set_dac_ch2", CMD_SET_DAC, 26'h0004ABC, ra, rb,
                {CMD_SET_DAC, 14'h1234, 14'h0ABC});
        add_row("get_adc", CMD_GET_ADC, 26'd0, ra, rb, {CMD_GET_ADC, rb, ra});
        add_row("signed_a", CMD_CHECK_SIGNED, 26'd0, ra, rb, signed_word(5'd0, a0));
        add_row("signed_b", CMD_CHECK_SIGNED, 26'd1, ra, rb, signed_word(5'd1, b0));
        add_row("stage_cos", CMD_SET_ROT_COEFFS, {10'd0, stage_cos}, ra, rb,
                {CMD_SET_ROT_COEFFS, 14'd0, stage_cos[15:2]});
        add_row("stage_sin", CMD_SET_ROT_COEFFS, {10'd1, stage_sin}, ra, rb,
                {CMD_SET_ROT_COEFFS, stage_sin[15:2], stage_cos[15:2]});
        add_row("staged_cos", CMD_CHECK_SIGNED, 26'd2, ra, rb, signed_word(5'd2, stage_cos));
        add_row("rot_cos_held", CMD_CHECK_SIGNED, 26'd4, ra, rb,
                signed_word(5'd4, `PDH_UNITY_COEFF));
        add_row("rot_sin_held", CMD_CHECK_SIGNED, 26'd5, ra, rb, signed_word(5'd5, '0));
        add_row("commit", CMD_COMMIT_ROT_COEFFS, 26'd0, rc, rd,
                {CMD_COMMIT_ROT_COEFFS, rot_q[15:2], rot_i[15:2]});
        add_row("rot_i", CMD_CHECK_SIGNED, 26'd6, rc, rd, signed_word(5'd6, rot_i));
        add_row("rot_q", CMD_CHECK_SIGNED, 26'd7, rc, rd, signed_word(5'd7, rot_q));
        add_row("rot_cos_new", CMD_CHECK_SIGNED, 26'd4, rc, rd, signed_word(5'd4, stage_cos));
        add_row("rot_sin_new", CMD_CHECK_SIGNED, 26'd5, rc, rd, signed_word(5'd5, stage_sin));
        add_row("bad_selector", CMD_CHECK_SIGNED, 26'd9, rc, rd, signed_word(5'd9, '0));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic       prev_sel;
        row_t       hold_row;
        gpio_word_t hold_rb;

        rst_i       = 1'b1;
        adc_dat_a   = '0;
        adc_dat_b   = '0;
        axi_from_ps = '0;
        void'($urandom(32'he9a2));
        ra = adc_word_t'($urandom);
        rb = adc_word_t'($urandom);
        rc = adc_word_t'($urandom);
        rd = adc_word_t'($urandom);
        build_table();

        repeat (5) tick();
        check_word("reset_readback", '0, axi_to_ps);
        check_led("reset_led", '0, led);
        check_bit("reset_dac_sel", 1'b0, dac_sel);
        check_bit("reset_dac_rst", 1'b1, dac_rst);
        check_dac("reset_dac_sel0", `PDH_DAC_MIDSCALE, dac_dat);
        rst_i = 1'b0;
        tick();
        check_bit("reset_dac_sel_next", 1'b1, dac_sel);
        check_bit("reset_dac_rst_release", 1'b0, dac_rst);
        check_dac("reset_dac_sel1", `PDH_DAC_MIDSCALE, dac_dat);

        foreach (rows[k]) begin
            apply_row(rows[k]);
        end

        check_led("led_after_table", 8'hA5, led);
        prev_sel = dac_sel;
        repeat (4) begin
            tick();
            check_bit("dac_sel_toggle", ~prev_sel, dac_sel);
            check_dac("dac_interleave", dac_sel ? 14'h0ABC : 14'h1234, dac_dat);
            prev_sel = dac_sel;
        end

        // New word with the strobe held high must not be taken
        hold_rb = {CMD_SET_LED, 20'd0, 8'h3C};
        hold_row.name     = "strobe_first_led";
        hold_row.cmd      = CMD_SET_LED;
        hold_row.data     = 26'h000003C;
        hold_row.adc_a    = ra;
        hold_row.adc_b    = rb;
        hold_row.expected = hold_rb;
        apply_row(hold_row);
        axi_from_ps = cmd_word(1'b1, CMD_SET_LED, 26'h00000C3);
        repeat (20) begin
            tick();
            check_led("strobe_hold_led", 8'h3C, led);
            check_word("strobe_hold_readback", hold_rb, axi_to_ps);
        end

        $display("Errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/pdh_pkg.sv
hw/pdh_cmd_capture.sv
hw/pdh_ctrl_regs.sv
hw/pdh_adc_frontend.sv
hw/pdh_iq_rotator.sv
hw/pdh_dac_mux.sv
hw/pdh_core.sv
tb/pdh_core_tb.sv

// ==== Bender.yml ====
package:
  name: pdh_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/pdh_pkg.sv
      - hw/pdh_cmd_capture.sv
      - hw/pdh_ctrl_regs.sv
      - hw/pdh_adc_frontend.sv
      - hw/pdh_iq_rotator.sv
      - hw/pdh_dac_mux.sv
      - hw/pdh_core.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/pdh_core_tb.sv
